/* rtl/commit_ctrl.sv */
// Commit FSM that times the shadow-to-active swap to a period boundary and holds the timer meanwhile
`timescale 1ns/1ps

module commit_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic commit_req,
    input  logic period_end,
    input  logic swap_done,
    output logic swap_strobe,
    output logic hold,
    output logic commit_pending,
    output logic commit_done
);

    pwm_pkg::commit_state_t state;
    pwm_pkg::commit_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            pwm_pkg::IDLE: begin
                if (commit_req) begin
                    state_nxt = pwm_pkg::ARMED;
                end
            end
            pwm_pkg::ARMED: begin
                // Requests arriving now are absorbed into this commit
                if (period_end) begin
                    state_nxt = pwm_pkg::SETTLE;
                end
            end
            pwm_pkg::SETTLE: begin
                if (swap_done) begin
                    state_nxt = pwm_pkg::IDLE;
                end
            end
            default: begin
                state_nxt = pwm_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pwm_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Swap fires in the boundary cycle itself so the count wraps into hold
    assign swap_strobe    = (state == pwm_pkg::ARMED) && period_end;
    assign hold           = (state == pwm_pkg::SETTLE);
    assign commit_pending = (state != pwm_pkg::IDLE);
    assign commit_done    = (state == pwm_pkg::SETTLE) && swap_done;

    // Hold window matches the buffer latency, then the timer is released
    a_settle_len : assert property (@(posedge clk) disable iff (!rst_n)
        swap_strobe |=> hold [*pwm_pkg::PIPE_DEPTH] ##1 !hold);

endmodule

/* rtl/period_timer.sv */
// Period counter that wraps at the active period and flags each boundary, frozen at zero under hold
`timescale 1ns/1ps

module period_timer (
    input  logic            clk,
    input  logic            rst_n,
    input  pwm_pkg::period_t period,
    input  logic            hold,
    output pwm_pkg::period_t count,
    output logic            period_end
);

    pwm_pkg::period_t eff_period;
    pwm_pkg::period_t last_count;
    logic             at_last;

    // Zero period runs as a single-cycle period
    assign eff_period = (period == '0) ? pwm_pkg::period_t'(1) : period;
    assign last_count = eff_period - pwm_pkg::period_t'(1);

    // Greater-or-equal also recovers if the period ever shrinks under a running count
    assign at_last    = (count >= last_count);

    assign period_end = !hold && at_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (hold) begin
            count <= '0;
        end else if (at_last) begin
            count <= '0;
        end else begin
            count <= count + pwm_pkg::period_t'(1);
        end
    end

    // Active period only changes during hold, so a free-running count never overshoots
    a_count_range : assert property (@(posedge clk) disable iff (!rst_n)
        !hold |-> (count < eff_period));

endmodule

/* rtl/pwm_compare.sv */
// Registered duty comparator that turns the period count into the PWM output
`timescale 1ns/1ps

module pwm_compare (
    input  logic             clk,
    input  logic             rst_n,
    input  pwm_pkg::period_t count,
    input  pwm_pkg::duty_t   duty,
    input  logic             hold,
    output logic             pwm_out
);

    logic high_nxt;

    // Duty at or above the period keeps every count below it, so the output stays high
    assign high_nxt = !hold && (count < duty);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_out <= 1'b0;
        end else begin
            pwm_out <= high_nxt;
        end
    end

endmodule

/* rtl/pwm_pkg.sv */
// Shared value types, controller states and pipeline depth for the double-buffered PWM design
package pwm_pkg;

    // Period length in clock cycles, a value of 0 behaves as 1
    typedef logic [15:0] period_t;

    // High cycles per period, saturates to always high at or above the period
    typedef logic [15:0] duty_t;

    // Commit sequencing
    //   IDLE   no transfer requested
    //   ARMED  waiting for the next period boundary
    //   SETTLE timer held while the swap travels through the buffers
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ARMED  = 2'd1,
        SETTLE = 2'd2
    } commit_state_t;

    // Cycles from a buffer strobe to its effect on the registers
    localparam int PIPE_DEPTH = 4;

endpackage

/* rtl/pwm_shadow_top.sv */
// Top level of the double-buffered PWM generator, connecting buffers, timer, commit FSM and comparator
`timescale 1ns/1ps

module pwm_shadow_top #(
    parameter int unsigned      WIDTH        = 16,
    parameter pwm_pkg::period_t RESET_PERIOD = 16'd8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cfg_write,
    input  pwm_pkg::period_t period_in,
    input  pwm_pkg::duty_t   duty_in,
    input  logic             commit_req,
    output logic             pwm_out,
    output pwm_pkg::period_t count,
    output pwm_pkg::period_t period_active,
    output pwm_pkg::duty_t   duty_active,
    output logic             commit_pending,
    output logic             commit_done
);

    logic period_end;
    logic swap_strobe;
    logic hold;
    logic swap_done;
    logic buf_valid;

    // Buffers carry the period and duty types directly
    if (WIDTH != $bits(pwm_pkg::period_t)) begin : g_width_check
        $error("WIDTH must match the period and duty width");
    end

    // Swap shares the strobe with writes and takes priority when both land together
    assign buf_valid = cfg_write | swap_strobe;

    shadow_reg_double_buf #(
        .WIDTH     (WIDTH),
        .RESET_VAL (RESET_PERIOD)
    ) u_period_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (buf_valid),
        .swap        (swap_strobe),
        .update_data (period_in),
        .active_data (period_active),
        .valid_out   (),
        .swap_done   (swap_done)
    );

    shadow_reg_double_buf #(
        .WIDTH     (WIDTH),
        .RESET_VAL ('0)
    ) u_duty_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (buf_valid),
        .swap        (swap_strobe),
        .update_data (duty_in),
        .active_data (duty_active),
        .valid_out   (),
        .swap_done   ()
    );

    period_timer u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .period     (period_active),
        .hold       (hold),
        .count      (count),
        .period_end (period_end)
    );

    commit_ctrl u_commit (
        .clk            (clk),
        .rst_n          (rst_n),
        .commit_req     (commit_req),
        .period_end     (period_end),
        .swap_done      (swap_done),
        .swap_strobe    (swap_strobe),
        .hold           (hold),
        .commit_pending (commit_pending),
        .commit_done    (commit_done)
    );

    pwm_compare u_compare (
        .clk     (clk),
        .rst_n   (rst_n),
        .count   (count),
        .duty    (duty_active),
        .hold    (hold),
        .pwm_out (pwm_out)
    );

endmodule

/* rtl/shadow_reg_double_buf.sv */
// Shadow/active register pair whose four-stage pipeline applies writes and swaps in strobe order
`timescale 1ns/1ps

module shadow_reg_double_buf #(
    parameter int unsigned      WIDTH     = 16,
    parameter logic [WIDTH-1:0] RESET_VAL = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_in,
    input  logic             swap,
    input  logic [WIDTH-1:0] update_data,
    output logic [WIDTH-1:0] active_data,
    output logic             valid_out,
    output logic             swap_done
);

    // Item tags per stage
    logic             valid_s1;
    logic             valid_s2;
    logic             valid_s3;
    logic             swap_s1;
    logic             swap_s2;
    logic             swap_s3;

    // Item payload per stage
    logic [WIDTH-1:0] data_s1;
    logic [WIDTH-1:0] data_s2;
    logic [WIDTH-1:0] data_s3;

    // Stage 4 storage
    logic [WIDTH-1:0] shadow_q;
    logic [WIDTH-1:0] active_q;

    // Tags move every cycle; a swap only counts when it comes with a strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            valid_s3 <= 1'b0;
            swap_s1  <= 1'b0;
            swap_s2  <= 1'b0;
            swap_s3  <= 1'b0;
        end else begin
            valid_s1 <= valid_in;
            swap_s1  <= valid_in & swap;
            valid_s2 <= valid_s1;
            swap_s2  <= swap_s1;
            valid_s3 <= valid_s2;
            swap_s3  <= swap_s2;
        end
    end

    // Payload follows its tag, held when the stage is empty
    always_ff @(posedge clk) begin
        if (valid_in) begin
            data_s1 <= update_data;
        end
        if (valid_s1) begin
            data_s2 <= data_s1;
        end
        if (valid_s2) begin
            data_s3 <= data_s2;
        end
    end

    // Stage 4 applies the item
    // A swap copies the shadow as it stands now, so a write one slot ahead is already in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shadow_q  <= RESET_VAL;
            active_q  <= RESET_VAL;
            valid_out <= 1'b0;
            swap_done <= 1'b0;
        end else begin
            valid_out <= valid_s3;
            swap_done <= valid_s3 & swap_s3;
            if (valid_s3) begin
                if (swap_s3) begin
                    active_q <= shadow_q;
                end else begin
                    shadow_q <= data_s3;
                end
            end
        end
    end

    assign active_data = active_q;

    // Swap strobe surfaces as swap_done a fixed pipeline depth later
    a_swap_latency : assert property (@(posedge clk) disable iff (!rst_n)
        (valid_in && swap) |-> ##(pwm_pkg::PIPE_DEPTH) (swap_done && valid_out));

endmodule

/* sources.f */
rtl/pwm_pkg.sv
rtl/shadow_reg_double_buf.sv
rtl/period_timer.sv
rtl/commit_ctrl.sv
rtl/pwm_compare.sv
rtl/pwm_shadow_top.sv
tb/pwm_shadow_tb.sv

/* tb/pwm_shadow_tb.sv */
// Testbench replaying the command file on the double-buffered PWM top against a reference model
`timescale 1ns/1ps

module pwm_shadow_tb;

    localparam int RESET_PERIOD = 8;

    logic        clk;
    logic        rst_n;
    logic        cfg_write;
    logic [15:0] period_in;
    logic [15:0] duty_in;
    logic        commit_req;
    logic        pwm_out;
    logic [15:0] count;
    logic [15:0] period_active;
    logic [15:0] duty_active;
    logic        commit_pending;
    logic        commit_done;

    // Reference model state
    int          shadow_p;
    int          shadow_d;
    int          act_p;
    int          act_d;
    int          exp_cnt;
    logic        exp_pwm;

    int          errors;
    int          checks;
    bit          stop_run;
    bit          reading;
    logic [15:0] lfsr_state;

    // Command file parsing
    int               fd;
    int               code;
    int               guard;
    int               arg_p;
    int               arg_d;
    int               arg_n;
    logic [7:0]       op;
    logic [8*96-1:0]  rest;

    pwm_shadow_top #(
        .WIDTH        (16),
        .RESET_PERIOD (RESET_PERIOD)
    ) DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_write      (cfg_write),
        .period_in      (period_in),
        .duty_in        (duty_in),
        .commit_req     (commit_req),
        .pwm_out        (pwm_out),
        .count          (count),
        .period_active  (period_active),
        .duty_active    (duty_active),
        .commit_pending (commit_pending),
        .commit_done    (commit_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_bits(input int nbits, output int val);
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            val = (val << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Zero period behaves as one cycle
    function automatic int eff_period(input int p);
        eff_period = (p == 0) ? 1 : p;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %0t: %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    // One idle or write cycle with the free-running count model
    task automatic advance_cycle(input bit restart);
        @(negedge clk);
        if (restart) begin
            exp_cnt = 0;
            exp_pwm = 1'b0;
        end else begin
            exp_pwm = (exp_cnt < act_d);
            exp_cnt = (exp_cnt + 1 >= eff_period(act_p)) ? 0 : exp_cnt + 1;
        end
        check_value("count", count, exp_cnt);
        check_value("pwm_out", pwm_out, exp_pwm);
        check_value("period_active", period_active, act_p);
        check_value("duty_active", duty_active, act_d);
        check_value("commit_pending", commit_pending, 0);
        check_value("commit_done", commit_done, 0);
    endtask

    task automatic run_idle(input int n);
        repeat (n) advance_cycle(1'b0);
    endtask

    task automatic write_config(input int p, input int d);
        int gap;
        period_in = p;
        duty_in   = d;
        cfg_write = 1'b1;
        advance_cycle(1'b0);
        cfg_write = 1'b0;
        shadow_p  = p;
        shadow_d  = d;
        random_bits(2, gap);
        run_idle(gap);
    endtask

    // Extra requests land while the commit is pending and must be absorbed
    task automatic run_commit(input int extra);
        int waited;
        int limit;
        int high_cnt;
        int eff;
        bit done_seen;
        limit = eff_period(act_p) + pwm_pkg::PIPE_DEPTH + 2;
        waited = 0;
        done_seen = 1'b0;
        commit_req = 1'b1;
        while (!done_seen && waited < limit) begin
            @(negedge clk);
            waited++;
            if (waited == 1) begin
                check_value("commit_pending", commit_pending, 1);
            end
            if (commit_done) begin
                done_seen = 1'b1;
            end
            commit_req = (waited <= extra);
        end
        commit_req = 1'b0;
        if (!done_seen) begin
            errors++;
            stop_run = 1'b1;
            $display("commit_done did not arrive within %0d cycles of the commit request", limit);
        end else begin
            check_value("period_active", period_active, shadow_p);
            check_value("duty_active", duty_active, shadow_d);
            check_value("count", count, 0);
            act_p = shadow_p;
            act_d = shadow_d;
            advance_cycle(1'b1);
            // First full period after the restart
            eff = eff_period(act_p);
            high_cnt = 0;
            for (int i = 0; i < eff; i++) begin
                advance_cycle(1'b0);
                if (pwm_out) begin
                    high_cnt++;
                end
            end
            check_value("pwm high cycles", high_cnt, (act_d < eff) ? act_d : eff);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        cfg_write  = 1'b0;
        period_in  = '0;
        duty_in    = '0;
        commit_req = 1'b0;
        errors     = 0;
        checks     = 0;
        stop_run   = 1'b0;
        lfsr_state = 16'd19998;
        shadow_p   = RESET_PERIOD;
        shadow_d   = 0;
        act_p      = RESET_PERIOD;
        act_d      = 0;
        exp_cnt    = 0;
        exp_pwm    = 1'b0;

        // Four rising edges in reset, released on a falling edge
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("period_active", period_active, RESET_PERIOD);
        check_value("duty_active", duty_active, 0);
        check_value("pwm_out", pwm_out, 0);
        check_value("commit_pending", commit_pending, 0);
        rst_n = 1'b1;

        fd = $fopen("tb/pwm_stim_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the command file tb/pwm_stim_input.txt");
        end else begin
            reading = 1'b1;
            guard = 0;
            while (reading && !stop_run && guard < 1000) begin
                guard++;
                code = $fscanf(fd, "%s", op);
                if (code != 1) begin
                    reading = 1'b0;
                end else if (op == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%d %d %d", arg_p, arg_d, arg_n);
                    if (code != 3) begin
                        errors++;
                        reading = 1'b0;
                        $display("command %s in the command file has missing fields", op);
                    end else if (op == "W") begin
                        write_config(arg_p, arg_d);
                    end else if (op == "C") begin
                        run_commit(arg_n);
                    end else if (op == "R") begin
                        run_idle(arg_n);
                    end else begin
                        errors++;
                        $display("unknown opcode %s in the command file", op);
                    end
                end
            end
            $fclose(fd);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* tb/pwm_stim_input.txt */
# op period duty cycles
# W writes shadows, C commits with cycles extra requests while pending, R idles for cycles
R 0 0 20
W 10 3 0
W 12 5 0
R 0 0 30
C 0 0 0
R 0 0 24
W 5 2 0
W 6 4 0
W 7 7 0
C 0 0 2
R 0 0 15
W 4 9 0
C 0 0 3
R 0 0 12
W 0 2 0
C 0 0 1
R 0 0 10
W 16 0 0
C 0 0 0
R 0 0 20
W 9 4 0
W 3 1 0
C 0 0 0
R 0 0 12
